//--- Makefile
# Verilator flow for the command encoder testbench

VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := tb_cmd_encoder
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/cmd_encoder_checker.sv
// Assertions on the encoder's internal handshakes
// Bound into every cmd_encoder_top, inactive while RST is high
`timescale 1ns/10ps

module cmd_encoder_checker (
    input logic                BUS_CLK,
    input logic                RST,
    input cmd_pkg::credit_t    credit_cnt,
    input logic                byte_valid,
    input logic                seq_gnt,
    input cmd_pkg::mem_req_t   bus_mem,
    input cmd_pkg::seq_state_t seq_state,
    input logic                serial_out
);

    // An underflow wraps above the limit, so one bound covers both ends
    credit_range: assert property (@(posedge BUS_CLK) disable iff (RST)
        credit_cnt <= cmd_pkg::credit_t'(cmd_pkg::SER_CREDITS))
        else $error("credit count %0d out of range", credit_cnt);

    byte_needs_credit: assert property (@(posedge BUS_CLK) disable iff (RST)
        byte_valid |-> credit_cnt != '0)
        else $error("byte sent with no credit left");

    idle_line: assert property (@(posedge BUS_CLK) disable iff (RST)
        seq_state == cmd_pkg::SEQ_INIT |-> !serial_out)
        else $error("serial_out high in SEQ_INIT");

    // Memory bytes must come from a granted cycle the bus left free
    grant_exclusive: assert property (@(posedge BUS_CLK) disable iff (RST)
        (byte_valid && seq_state == cmd_pkg::SEQ_DATA) |-> $past(seq_gnt && !bus_mem.en))
        else $error("sequencer took memory data from a cycle held by the bus");

endmodule

bind cmd_encoder_top cmd_encoder_checker cmd_encoder_checker_i (
    .BUS_CLK    (BUS_CLK),
    .RST        (RST),
    .credit_cnt (cmd_sequencer_i.credit_cnt),
    .byte_valid (byte_valid),
    .seq_gnt    (seq_gnt),
    .bus_mem    (bus_mem),
    .seq_state  (seq_state),
    .serial_out (serial_out)
);

//--- bench/tb_cmd_encoder.sv
// Testbench for the command encoder, table driven
// Each row starts from a soft reset, so no sync bytes are left in the serializer
// Stream alignment needs bit 0 of the first byte set
`timescale 1ns/10ps

module tb_cmd_encoder;

    localparam int NUM_ROWS     = 6;
    localparam int CAPTURE_WAIT = 200;
    // Bus addresses read during transmission, clear of every sequence
    localparam logic [15:0] SPARE_BASE = 16'd640;

    typedef struct packed {
        logic [15:0]     len;
        logic [15:0]     rep;
        logic [7:0]      nsync;
        logic            traffic;
        logic [7:0][7:0] data;
    } row_t;

    logic        BUS_CLK;
    logic        RST;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    logic [7:0]  bus_data_out;
    logic        serial_out;

    row_t        rows [NUM_ROWS];
    logic [15:0] lfsr;
    logic        table_ready;
    int          err_cnt;
    int          check_cnt;

    cmd_encoder_top cmd_encoder_top_i (.*);

    initial begin
        BUS_CLK = 1'b0;
        forever #5 BUS_CLK = ~BUS_CLK;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[7:0] ^ a[15:8] ^ 8'hA5;
    endfunction

    // Data bytes repeated, then 0x81 and 0x7E in turn
    function automatic logic [7:0] expected_byte(input row_t r, input int k);
        int         data_bytes;
        logic [2:0] idx;
        data_bytes = (r.len == 16'd0 || r.rep == 16'd0) ? 0 : int'(r.len) * int'(r.rep);
        if (k < data_bytes) begin
            idx = 3'(k % int'(r.len));
            return r.data[idx];
        end
        return ((k - data_bytes) % 2 == 0) ? 8'h81 : 8'h7E;
    endfunction

    task automatic set_row(input int idx, input int len, input int rep, input int nsync,
                           input logic traffic);
        row_t r;
        r.len     = 16'(len);
        r.rep     = 16'(rep);
        r.nsync   = 8'(nsync);
        r.traffic = traffic;
        for (int b = 0; b < 8; b++) begin
            for (int t = 0; t < 8; t++) begin
                lfsr         = lfsr_step(lfsr);
                r.data[b][t] = lfsr[0];
            end
        end
        r.data[0][0] = 1'b1;
        rows[idx]    = r;
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("** Error at %0t: %s expected 0x%02h, actual 0x%02h",
                     $time, name, expected, actual);
        end
    endtask

    // Bus tasks start and end 1 ns after a rising edge
    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(posedge BUS_CLK);
        #1;
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(posedge BUS_CLK);
        #1;
        bus_rd = 1'b0;
        data   = bus_data_out;
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [7:0] expected,
                              input string name);
        logic [7:0] d;
        bus_read(addr, d);
        check_value(name, expected, d);
    endtask

    task automatic check_register_map();
        read_check(bus_pkg::ADDR_RESET, bus_pkg::VERSION, "version");
        @(posedge BUS_CLK);
        #1;
        check_value("bus_data_out idle", 8'h00, bus_data_out);
        read_check(bus_pkg::ADDR_REPEAT_LO, 8'h01, "repeat_lo");
        read_check(bus_pkg::ADDR_REPEAT_HI, 8'h00, "repeat_hi");
        read_check(bus_pkg::ADDR_MEMSIZE_LO, 8'h00, "memsize_lo");
        read_check(bus_pkg::ADDR_MEMSIZE_HI, 8'h04, "memsize_hi");
        read_check(bus_pkg::ADDR_START, 8'h01, "status");
        bus_write(bus_pkg::ADDR_SIZE_LO, 8'h5A);
        bus_write(bus_pkg::ADDR_SIZE_HI, 8'hC3);
        read_check(bus_pkg::ADDR_SIZE_LO, 8'h5A, "size_lo");
        read_check(bus_pkg::ADDR_SIZE_HI, 8'hC3, "size_hi");
        read_check(16'd2, 8'h00, "unmapped 2");
        read_check(16'd9, 8'h00, "unmapped 9");
        read_check(16'd15, 8'h00, "unmapped 15");
        read_check(16'd1040, 8'h00, "unmapped 1040");
        read_check(16'hFFFF, 8'h00, "unmapped 0xffff");
    endtask

    task automatic check_memory();
        logic [15:0] addrs [12];
        addrs[0] = 16'd16;
        addrs[1] = 16'd17;
        addrs[2] = 16'd527;
        addrs[3] = 16'd1039;
        for (int i = 0; i < 8; i++) begin
            addrs[4 + i] = SPARE_BASE + 16'(i);
        end
        foreach (addrs[i]) begin
            bus_write(addrs[i], fill_byte(addrs[i]));
        end
        foreach (addrs[i]) begin
            read_check(addrs[i], fill_byte(addrs[i]), $sformatf("mem[%0d]", addrs[i]));
        end
    endtask

    task automatic capture_stream(input row_t r, input int nbytes);
        int         waited;
        logic [7:0] got;
        waited = 0;
        while (serial_out !== 1'b1) begin
            if (waited == CAPTURE_WAIT) begin
                err_cnt++;
                $display("ERROR at %0t: serial_out stayed low for %0d cycles after start",
                         $time, CAPTURE_WAIT);
                return;
            end
            @(posedge BUS_CLK);
            #1;
            waited++;
        end
        // LSB first
        for (int k = 0; k < nbytes; k++) begin
            for (int b = 0; b < 8; b++) begin
                got[b] = serial_out;
                @(posedge BUS_CLK);
                #1;
            end
            check_value($sformatf("serial byte %0d", k), expected_byte(r, k), got);
        end
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   data_bytes;
        r          = rows[idx];
        data_bytes = (r.len == 16'd0 || r.rep == 16'd0) ? 0 : int'(r.len) * int'(r.rep);
        bus_write(bus_pkg::ADDR_RESET, 8'h00);
        for (int i = 0; i < 8; i++) begin
            bus_write(bus_pkg::REG_SPACE + 16'(i), r.data[i]);
        end
        bus_write(bus_pkg::ADDR_SIZE_LO, r.len[7:0]);
        bus_write(bus_pkg::ADDR_SIZE_HI, r.len[15:8]);
        bus_write(bus_pkg::ADDR_REPEAT_LO, r.rep[7:0]);
        bus_write(bus_pkg::ADDR_REPEAT_HI, r.rep[15:8]);
        bus_write(bus_pkg::ADDR_START, 8'h01);
        fork
            capture_stream(r, data_bytes + int'(r.nsync));
            begin
                read_check(bus_pkg::ADDR_START, (data_bytes > 0) ? 8'h00 : 8'h03,
                           "status at start");
                // Memory reads with an idle cycle between them
                for (int i = 0; i < 8 && r.traffic; i++) begin
                    read_check(SPARE_BASE + 16'(i), fill_byte(SPARE_BASE + 16'(i)),
                               $sformatf("mem[%0d] during transmission", SPARE_BASE + 16'(i)));
                    @(posedge BUS_CLK);
                    #1;
                end
            end
        join
        read_check(bus_pkg::ADDR_START, 8'h03, "status after data");
    endtask

    task automatic check_soft_reset();
        bus_write(bus_pkg::ADDR_RESET, 8'h00);
        bus_write(bus_pkg::ADDR_SIZE_LO, 8'd8);
        bus_write(bus_pkg::ADDR_REPEAT_LO, 8'd20);
        bus_write(bus_pkg::ADDR_START, 8'h01);
        repeat (40) @(posedge BUS_CLK);
        #1;
        bus_write(bus_pkg::ADDR_RESET, 8'h00);
        for (int c = 0; c < 50; c++) begin
            check_value("serial_out after soft reset", 8'h00, {7'b0, serial_out});
            @(posedge BUS_CLK);
            #1;
        end
        read_check(bus_pkg::ADDR_START, 8'h01, "status after soft reset");
        read_check(bus_pkg::ADDR_REPEAT_LO, 8'h01, "repeat_lo after soft reset");
    endtask

    initial begin
        RST         = 1'b1;
        bus_add     = '0;
        bus_data_in = '0;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        err_cnt     = 0;
        check_cnt   = 0;
        table_ready = 1'b0;
        lfsr        = 16'd81;
        // Row: length, repeat, sync bytes, bus traffic
        set_row(0, 1, 1, 4, 1'b0);
        set_row(1, 4, 3, 4, 1'b0);
        set_row(2, 8, 2, 6, 1'b1);
        set_row(3, 0, 2, 4, 1'b0);
        set_row(4, 5, 0, 4, 1'b0);
        set_row(5, 3, 5, 3, 1'b1);
        table_ready = 1'b1;
        repeat (5) @(posedge BUS_CLK);
        #1;
        RST = 1'b0;
        check_register_map();
        check_memory();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        check_soft_reset();
        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (table_ready === 1'b1);
        limit = 2000;
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit += (int'(rows[i].len) * int'(rows[i].rep) + int'(rows[i].nsync) + 20) * 8;
        end
        repeat (limit) @(posedge BUS_CLK);
        $display("ERROR: run did not finish within %0d cycles", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- source/bus_pkg.sv
// Host register bus definitions
// Addresses below REG_SPACE are registers, the command memory follows
// Unmapped register addresses read as 0

package bus_pkg;

    // One host bus cycle
    typedef struct packed {
        logic [15:0] add;
        logic [7:0]  wdata;
        logic        rd;
        logic        wr;
    } bus_req_t;

    // Register map
    localparam logic [15:0] ADDR_RESET      = 16'd0;
    localparam logic [15:0] ADDR_START      = 16'd1;
    localparam logic [15:0] ADDR_SIZE_LO    = 16'd3;
    localparam logic [15:0] ADDR_SIZE_HI    = 16'd4;
    localparam logic [15:0] ADDR_REPEAT_LO  = 16'd5;
    localparam logic [15:0] ADDR_REPEAT_HI  = 16'd6;
    localparam logic [15:0] ADDR_MEMSIZE_LO = 16'd7;
    localparam logic [15:0] ADDR_MEMSIZE_HI = 16'd8;

    // First command memory address
    localparam logic [15:0] REG_SPACE = 16'd16;

    localparam logic [7:0] VERSION = 8'd1;

endpackage

//--- source/cmd_encoder_top.sv
// Command encoder top level, all blocks on BUS_CLK
// Serial output carries one bit per clock cycle
`timescale 1ns/10ps

module cmd_encoder_top (
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_data_in,
    input  logic        bus_rd,
    input  logic        bus_wr,
    output logic [7:0]  bus_data_out,
    output logic        serial_out
);

    bus_pkg::bus_req_t   bus_req;
    cmd_pkg::mem_req_t   bus_mem;
    cmd_pkg::mem_req_t   seq_mem;
    cmd_pkg::cmd_conf_t  conf;
    cmd_pkg::seq_state_t seq_state;
    logic                seq_gnt;
    logic [7:0]          mem_rdata;
    logic                start;
    logic                clear;
    logic                byte_valid;
    logic [7:0]          byte_data;
    logic                credit_ret;

    assign bus_req.add   = bus_add;
    assign bus_req.wdata = bus_data_in;
    assign bus_req.rd    = bus_rd;
    assign bus_req.wr    = bus_wr;

    cmd_regs cmd_regs_i (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .bus          (bus_req),
        .mem_rdata    (mem_rdata),
        .seq_state    (seq_state),
        .bus_data_out (bus_data_out),
        .bus_mem      (bus_mem),
        .conf         (conf),
        .start        (start),
        .clear        (clear)
    );

    cmd_mem_arbiter cmd_mem_arbiter_i (
        .BUS_CLK   (BUS_CLK),
        .bus_mem   (bus_mem),
        .seq_mem   (seq_mem),
        .seq_gnt   (seq_gnt),
        .mem_rdata (mem_rdata)
    );

    cmd_sequencer cmd_sequencer_i (
        .BUS_CLK    (BUS_CLK),
        .RST        (RST),
        .clear      (clear),
        .start      (start),
        .conf       (conf),
        .seq_gnt    (seq_gnt),
        .mem_rdata  (mem_rdata),
        .credit_ret (credit_ret),
        .seq_mem    (seq_mem),
        .seq_state  (seq_state),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    cmd_serializer cmd_serializer_i (
        .BUS_CLK    (BUS_CLK),
        .RST        (RST),
        .clear      (clear),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .credit_ret (credit_ret),
        .serial_out (serial_out)
    );

endmodule

//--- source/cmd_mem_arbiter.sv
// Single-port 1024x8 command memory with a fixed-priority arbiter
// The bus always wins, the sequencer is granted only on idle bus cycles
// Read data appears one cycle after the served access
`timescale 1ns/10ps

module cmd_mem_arbiter (
    input  logic              BUS_CLK,
    input  cmd_pkg::mem_req_t bus_mem,
    input  cmd_pkg::mem_req_t seq_mem,
    output logic              seq_gnt,
    output logic [7:0]        mem_rdata
);

    cmd_pkg::mem_req_t sel;

    logic [7:0] mem [cmd_pkg::MEM_DEPTH];

    // Sequencer only gets the port when the bus leaves it free
    assign seq_gnt = seq_mem.en && !bus_mem.en;

    always_comb begin
        if (bus_mem.en) begin
            sel = bus_mem;
        end else begin
            sel = seq_mem;
        end
    end

    // Read-first port, output holds between accesses
    always_ff @(posedge BUS_CLK) begin
        if (sel.en) begin
            if (sel.we) begin
                mem[sel.addr] <= sel.wdata;
            end
            mem_rdata <= mem[sel.addr];
        end
    end

endmodule

//--- source/cmd_pkg.sv
// Command encoder definitions shared by the datapath blocks
// The serializer buffer logic assumes SER_CREDITS is 2
// Sync bytes go out high byte first

package cmd_pkg;

    // Command memory geometry
    localparam int MEM_AW    = 10;
    localparam int MEM_DEPTH = 2 ** MEM_AW;

    localparam logic [15:0] SYNC_PATTERN = 16'h817E;

    // Serializer buffer depth, one credit per entry
    localparam int SER_CREDITS = 2;
    localparam int CREDIT_W    = $clog2(SER_CREDITS + 1);

    typedef logic [CREDIT_W-1:0] credit_t;

    // One access to the command memory
    typedef struct packed {
        logic              en;
        logic              we;
        logic [MEM_AW-1:0] addr;
        logic [7:0]        wdata;
    } mem_req_t;

    // Sequence configuration from the register block
    typedef struct packed {
        logic [15:0] size;
        logic [15:0] repeat_count;
    } cmd_conf_t;

    typedef enum logic [1:0] {SEQ_INIT, SEQ_DATA, SEQ_SYNC} seq_state_t;

endpackage

//--- source/cmd_regs.sv
// Host bus decoder and configuration registers
// Writes take effect on the edge where wr is high, reads return one cycle later
// clear covers both RST and a write to the reset register
`timescale 1ns/10ps

module cmd_regs (
    input  logic                BUS_CLK,
    input  logic                RST,
    input  bus_pkg::bus_req_t   bus,
    input  logic [7:0]          mem_rdata,
    input  cmd_pkg::seq_state_t seq_state,
    output logic [7:0]          bus_data_out,
    output cmd_pkg::mem_req_t   bus_mem,
    output cmd_pkg::cmd_conf_t  conf,
    output logic                start,
    output logic                clear
);

    logic [15:0] mem_off;
    logic        in_mem;
    logic        rd_q;
    logic        rd_mem_q;
    logic [15:0] rd_add_q;
    logic [7:0]  reg_rdata;

    assign mem_off  = bus.add - bus_pkg::REG_SPACE;
    assign in_mem   = (bus.add >= bus_pkg::REG_SPACE) && (mem_off[15:cmd_pkg::MEM_AW] == '0);

    assign clear = RST || (bus.wr && bus.add == bus_pkg::ADDR_RESET);
    assign start = bus.wr && bus.add == bus_pkg::ADDR_START;

    // Memory window request
    assign bus_mem.en    = (bus.rd || bus.wr) && in_mem;
    assign bus_mem.we    = bus.wr;
    assign bus_mem.addr  = mem_off[cmd_pkg::MEM_AW-1:0];
    assign bus_mem.wdata = bus.wdata;

    always_ff @(posedge BUS_CLK) begin
        if (clear) begin
            conf.size         <= '0;
            conf.repeat_count <= 16'd1;
        end else if (bus.wr) begin
            case (bus.add)
                bus_pkg::ADDR_SIZE_LO:   conf.size[7:0]          <= bus.wdata;
                bus_pkg::ADDR_SIZE_HI:   conf.size[15:8]         <= bus.wdata;
                bus_pkg::ADDR_REPEAT_LO: conf.repeat_count[7:0]  <= bus.wdata;
                bus_pkg::ADDR_REPEAT_HI: conf.repeat_count[15:8] <= bus.wdata;
                default: ;
            endcase
        end
    end

    // Read address pipeline, one cycle of latency to match the memory
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            rd_q     <= 1'b0;
            rd_mem_q <= 1'b0;
            rd_add_q <= '0;
        end else begin
            rd_q     <= bus.rd;
            rd_mem_q <= bus.rd && in_mem;
            rd_add_q <= bus.add;
        end
    end

    always_comb begin
        case (rd_add_q)
            bus_pkg::ADDR_RESET:      reg_rdata = bus_pkg::VERSION;
            // Status: bit 1 syncing, bit 0 done
            bus_pkg::ADDR_START:      reg_rdata = {6'b0, seq_state == cmd_pkg::SEQ_SYNC,
                                                   seq_state != cmd_pkg::SEQ_DATA};
            bus_pkg::ADDR_SIZE_LO:    reg_rdata = conf.size[7:0];
            bus_pkg::ADDR_SIZE_HI:    reg_rdata = conf.size[15:8];
            bus_pkg::ADDR_REPEAT_LO:  reg_rdata = conf.repeat_count[7:0];
            bus_pkg::ADDR_REPEAT_HI:  reg_rdata = conf.repeat_count[15:8];
            bus_pkg::ADDR_MEMSIZE_LO: reg_rdata = 8'(cmd_pkg::MEM_DEPTH);
            bus_pkg::ADDR_MEMSIZE_HI: reg_rdata = 8'(cmd_pkg::MEM_DEPTH >> 8);
            default:                  reg_rdata = 8'h00;
        endcase
    end

    assign bus_data_out = !rd_q ? 8'h00 : (rd_mem_q ? mem_rdata : reg_rdata);

endmodule

//--- source/cmd_sequencer.sv
// Command sequencer, fetches the sequence and feeds the serializer
// One fetch is in flight at a time, started only while a credit is left
// A start restarts the sequence from offset 0, credits carry over
`timescale 1ns/10ps

module cmd_sequencer (
    input  logic                BUS_CLK,
    input  logic                RST,
    input  logic                clear,
    input  logic                start,
    input  cmd_pkg::cmd_conf_t  conf,
    input  logic                seq_gnt,
    input  logic [7:0]          mem_rdata,
    input  logic                credit_ret,
    output cmd_pkg::mem_req_t   seq_mem,
    output cmd_pkg::seq_state_t seq_state,
    output logic                byte_valid,
    output logic [7:0]          byte_data
);

    cmd_pkg::seq_state_t state_q;
    cmd_pkg::credit_t    credit_cnt;
    logic [15:0]         idx_q;
    logic [15:0]         rep_q;
    logic                fetch_q;
    logic                wait_q;
    logic                sync_lo_q;
    logic                last_byte;
    logic                last_rep;
    logic                sync_emit;

    assign last_byte = (idx_q + 16'd1) >= conf.size;
    assign last_rep  = (rep_q + 16'd1) >= conf.repeat_count;
    assign sync_emit = (state_q == cmd_pkg::SEQ_SYNC) && (credit_cnt != '0);

    assign seq_mem.en    = fetch_q;
    assign seq_mem.we    = 1'b0;
    assign seq_mem.addr  = idx_q[cmd_pkg::MEM_AW-1:0];
    assign seq_mem.wdata = 8'h00;

    assign seq_state  = state_q;
    // Memory data is emitted in the cycle it arrives
    assign byte_valid = wait_q || sync_emit;
    assign byte_data  = !sync_emit ? mem_rdata :
                        (sync_lo_q ? cmd_pkg::SYNC_PATTERN[7:0] : cmd_pkg::SYNC_PATTERN[15:8]);

    always_ff @(posedge BUS_CLK) begin
        if (RST || clear) begin
            state_q   <= cmd_pkg::SEQ_INIT;
            idx_q     <= '0;
            rep_q     <= '0;
            fetch_q   <= 1'b0;
            wait_q    <= 1'b0;
            sync_lo_q <= 1'b0;
        end else if (start) begin
            state_q   <= (conf.size != '0 && conf.repeat_count != '0) ? cmd_pkg::SEQ_DATA
                                                                     : cmd_pkg::SEQ_SYNC;
            idx_q     <= '0;
            rep_q     <= '0;
            fetch_q   <= 1'b0;
            wait_q    <= 1'b0;
            sync_lo_q <= 1'b0;
        end else begin
            if (state_q == cmd_pkg::SEQ_DATA) begin
                if (wait_q) begin
                    wait_q <= 1'b0;
                    if (!last_byte) begin
                        idx_q <= idx_q + 16'd1;
                    end else begin
                        idx_q <= '0;
                        if (last_rep) begin
                            state_q <= cmd_pkg::SEQ_SYNC;
                        end else begin
                            rep_q <= rep_q + 16'd1;
                        end
                    end
                end else if (fetch_q) begin
                    // Request held until the arbiter grants it
                    if (seq_gnt) begin
                        fetch_q <= 1'b0;
                        wait_q  <= 1'b1;
                    end
                end else if (credit_cnt != '0) begin
                    fetch_q <= 1'b1;
                end
            end
            if (sync_emit) begin
                sync_lo_q <= !sync_lo_q;
            end
        end
    end

    // Credits, one per free serializer buffer entry
    always_ff @(posedge BUS_CLK) begin
        if (RST || clear) begin
            credit_cnt <= cmd_pkg::credit_t'(cmd_pkg::SER_CREDITS);
        end else if (byte_valid && !credit_ret) begin
            credit_cnt <= credit_cnt - cmd_pkg::credit_t'(1);
        end else if (credit_ret && !byte_valid) begin
            credit_cnt <= credit_cnt + cmd_pkg::credit_t'(1);
        end
    end

endmodule

//--- source/cmd_serializer.sv
// Two-entry byte buffer and LSB-first serializer, one bit per cycle
// A credit returns when a byte moves from the buffer to the shifter
// The line idles at 0 while no byte is being shifted
`timescale 1ns/10ps

module cmd_serializer (
    input  logic       BUS_CLK,
    input  logic       RST,
    input  logic       clear,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    output logic       credit_ret,
    output logic       serial_out
);

    logic [7:0]       buf_q [cmd_pkg::SER_CREDITS];
    logic             wr_ptr_q;
    logic             rd_ptr_q;
    cmd_pkg::credit_t count_q;
    logic [7:0]       shift_q;
    logic [2:0]       bit_cnt_q;
    logic             active_q;
    logic             boundary;
    logic             load;

    // Byte boundary when idle or on the last bit
    assign boundary   = !active_q || (bit_cnt_q == 3'd7);
    assign load       = boundary && (count_q != '0);
    assign credit_ret = load;
    assign serial_out = active_q && shift_q[0];

    always_ff @(posedge BUS_CLK) begin
        if (byte_valid) begin
            buf_q[wr_ptr_q] <= byte_data;
        end
        if (load) begin
            shift_q <= buf_q[rd_ptr_q];
        end else begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST || clear) begin
            wr_ptr_q  <= 1'b0;
            rd_ptr_q  <= 1'b0;
            count_q   <= '0;
            active_q  <= 1'b0;
            bit_cnt_q <= '0;
        end else begin
            if (byte_valid) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (load) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            if (byte_valid && !load) begin
                count_q <= count_q + cmd_pkg::credit_t'(1);
            end else if (load && !byte_valid) begin
                count_q <= count_q - cmd_pkg::credit_t'(1);
            end
            if (load) begin
                active_q  <= 1'b1;
                bit_cnt_q <= '0;
            end else if (boundary) begin
                active_q <= 1'b0;
            end else begin
                bit_cnt_q <= bit_cnt_q + 3'd1;
            end
        end
    end

endmodule

//--- tb.f
source/bus_pkg.sv
source/cmd_pkg.sv
source/cmd_regs.sv
source/cmd_mem_arbiter.sv
source/cmd_sequencer.sv
source/cmd_serializer.sv
source/cmd_encoder_top.sv
bench/cmd_encoder_checker.sv
bench/tb_cmd_encoder.sv
